// ==== rtl/input_defines.svh ====
`ifndef INPUT_DEFINES_SVH
`define INPUT_DEFINES_SVH

// width of the value handed to the CPU
`define INPUT_DATA_WIDTH 32

// slide switches on the board
`define INPUT_SW_WIDTH 16

// the display holds ten decimal digits, the last two light the overflow LEDs
`define INPUT_MAX_DIGITS 10

// cycles a sampled value has to hold before it is trusted
// small for simulation, a board build wants milliseconds here
`define INPUT_DEBOUNCE_CYCLES 4

// cycles each keypad row stays driven, longer than the debounce time
`define INPUT_SCAN_CYCLES 8

`endif

// ==== rtl/input_pkg.sv ====
`include "input_defines.svh"

package input_pkg;

    // {row nibble, column nibble}, both active low
    typedef logic [7:0] key_coord_t;

    typedef logic [`INPUT_DATA_WIDTH-1:0]            data_word_t;
    typedef logic [`INPUT_SW_WIDTH-1:0]              switch_word_t;
    typedef logic [$clog2(`INPUT_MAX_DIGITS+1)-1:0]  digit_count_t;

    typedef enum logic [1:0] {
        IDLE,       // no request from the CPU
        KEYPAD,     // digits are being typed
        SWITCH,     // value comes from the slide switches
        PAUSE       // CPU held by the user
    } entry_state_t;

    localparam key_coord_t KEY_NONE      = 8'b1111_1111;

    localparam key_coord_t KEY_ZERO      = 8'b0111_1101;
    localparam key_coord_t KEY_ONE       = 8'b1110_1110;
    localparam key_coord_t KEY_TWO       = 8'b1110_1101;
    localparam key_coord_t KEY_THREE     = 8'b1110_1011;
    localparam key_coord_t KEY_FOUR      = 8'b1101_1110;
    localparam key_coord_t KEY_FIVE      = 8'b1101_1101;
    localparam key_coord_t KEY_SIX       = 8'b1101_1011;
    localparam key_coord_t KEY_SEVEN     = 8'b1011_1110;
    localparam key_coord_t KEY_EIGHT     = 8'b1011_1101;
    localparam key_coord_t KEY_NINE      = 8'b1011_1011;

    localparam key_coord_t KEY_BACKSPACE = 8'b0111_1110;  // "*"
    localparam key_coord_t KEY_ENTER     = 8'b0111_1011;  // "#"
    localparam key_coord_t KEY_PAUSE     = 8'b1110_0111;  // "A"
    localparam key_coord_t KEY_SWITCH    = 8'b1101_0111;  // "B"

endpackage

// ==== rtl/entry_if.sv ====
`timescale 1ns/1ps

interface entry_if;
    import input_pkg::*;

    logic         start;        // pulse, CPU request accepted
    logic         complete;     // pulse, user pressed enter
    data_word_t   value;
    logic         from_switch;  // switches hold the answer, not value
    digit_count_t digit_count;

    modport entry (
        input  start,
        output complete,
        output value,
        output from_switch,
        output digit_count
    );

    modport resolver (
        output start,
        input  complete,
        input  value,
        input  from_switch,
        input  digit_count
    );

endinterface

// ==== rtl/stable_filter.sv ====
`timescale 1ns/1ps
`include "input_defines.svh"

module stable_filter #(
    parameter type      payload_t   = logic [7:0],
    parameter payload_t reset_value = '0
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t raw,
    output payload_t stable
);

    localparam int               CNT_W       = $clog2(`INPUT_DEBOUNCE_CYCLES + 1);
    localparam logic [CNT_W-1:0] HOLD_CYCLES = CNT_W'(`INPUT_DEBOUNCE_CYCLES);

    payload_t         raw_q;     // last sampled input
    logic [CNT_W-1:0] hold_cnt;  // cycles raw_q has not moved

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            raw_q    <= reset_value;
            hold_cnt <= '0;
            stable   <= reset_value;
        end else begin
            raw_q <= raw;
            if (raw != raw_q) begin
                hold_cnt <= CNT_W'(1);  // new value is held from this edge on
            end else if (hold_cnt != HOLD_CYCLES) begin
                hold_cnt <= hold_cnt + 1'b1;
            end
            if (hold_cnt == HOLD_CYCLES) begin
                stable <= raw_q;
            end
        end
    end

endmodule

// ==== rtl/keypad_scanner.sv ====
`timescale 1ns/1ps
`include "input_defines.svh"

module keypad_scanner (
    input  logic                  clk,
    input  logic                  rst_n,
    output logic [3:0]            key_row,
    input  logic [3:0]            key_col,
    output logic                  key_valid,
    output input_pkg::key_coord_t key_coord
);
    import input_pkg::*;

    localparam int                SCAN_W    = $clog2(`INPUT_SCAN_CYCLES);
    localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(`INPUT_SCAN_CYCLES - 1);

    logic [SCAN_W-1:0] scan_cnt;
    logic [3:0]        row_d1;
    logic [3:0]        row_q;    // row that was driven when col_q was seen
    logic [3:0]        col_meta; // columns come straight from the board
    logic [3:0]        col_q;
    logic              col_hit;
    key_coord_t        raw_coord;
    key_coord_t        filt_coord;
    key_coord_t        filt_prev;

    assign col_hit   = (col_q != 4'hF);
    assign raw_coord = col_hit ? {row_q, col_q} : KEY_NONE;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_row  <= 4'b1110;
            scan_cnt <= '0;
            row_d1   <= 4'hF;
            row_q    <= 4'hF;
            col_meta <= 4'hF;
            col_q    <= 4'hF;
        end else begin
            row_d1   <= key_row;  // row delayed to line up with the column sync
            row_q    <= row_d1;
            col_meta <= key_col;
            col_q    <= col_meta;
            if (col_hit) begin
                scan_cnt <= '0;  // stay on this row while a key is down
            end else if (scan_cnt == SCAN_LAST) begin
                scan_cnt <= '0;
                key_row  <= {key_row[2:0], key_row[3]};
            end else begin
                scan_cnt <= scan_cnt + 1'b1;
            end
        end
    end

    stable_filter #(
        .payload_t   (key_coord_t),
        .reset_value (KEY_NONE)
    ) u_coord_filter (
        .clk    (clk),
        .rst_n  (rst_n),
        .raw    (raw_coord),
        .stable (filt_coord)
    );

    // one event per press, the key must be released before the next one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            filt_prev <= KEY_NONE;
            key_valid <= 1'b0;
            key_coord <= KEY_NONE;
        end else begin
            filt_prev <= filt_coord;
            key_valid <= (filt_prev == KEY_NONE) && (filt_coord != KEY_NONE);
            key_coord <= filt_coord;
        end
    end

endmodule

// ==== rtl/decimal_entry.sv ====
`timescale 1ns/1ps
`include "input_defines.svh"

module decimal_entry (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  key_valid,
    input  input_pkg::key_coord_t key_coord,
    input  logic                  ignore_pause,
    output logic                  cpu_pause,
    output logic                  overflow_9th,
    output logic                  overflow_10th,
    entry_if.entry                entry
);
    import input_pkg::*;

    localparam digit_count_t MAX_DIGITS = digit_count_t'(`INPUT_MAX_DIGITS);

    entry_state_t state;
    entry_state_t resume_state;  // state that "A" returns to
    logic         digit_hit;
    logic [3:0]   digit_val;
    logic         take_digit;
    logic         pause_key;

    always_comb begin
        digit_hit = 1'b1;
        digit_val = 4'd0;
        case (key_coord)
            KEY_ZERO:  digit_val = 4'd0;
            KEY_ONE:   digit_val = 4'd1;
            KEY_TWO:   digit_val = 4'd2;
            KEY_THREE: digit_val = 4'd3;
            KEY_FOUR:  digit_val = 4'd4;
            KEY_FIVE:  digit_val = 4'd5;
            KEY_SIX:   digit_val = 4'd6;
            KEY_SEVEN: digit_val = 4'd7;
            KEY_EIGHT: digit_val = 4'd8;
            KEY_NINE:  digit_val = 4'd9;
            default:   digit_hit = 1'b0;
        endcase
    end

    // a zero in front of an empty value is not a digit
    assign take_digit = key_valid && digit_hit && (entry.digit_count < MAX_DIGITS) &&
                        ((digit_val != 4'd0) || (entry.value != '0));
    assign pause_key  = key_valid && (key_coord == KEY_PAUSE);

    assign overflow_9th  = (entry.digit_count >= MAX_DIGITS - 1'b1);
    assign overflow_10th = (entry.digit_count == MAX_DIGITS);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state             <= IDLE;
            resume_state      <= IDLE;
            cpu_pause         <= 1'b0;
            entry.complete    <= 1'b0;
            entry.value       <= '0;
            entry.from_switch <= 1'b0;
            entry.digit_count <= '0;
        end else begin
            entry.complete <= 1'b0;
            if (entry.start) begin  // new request starts from an empty value
                entry.value       <= '0;
                entry.from_switch <= 1'b0;
            end
            if (pause_key && state != PAUSE) begin
                state        <= PAUSE;
                resume_state <= entry.start ? KEYPAD : state;
                cpu_pause    <= 1'b1;
            end else begin
                case (state)
                    IDLE: begin
                        if (entry.start) begin
                            state <= KEYPAD;
                        end
                    end
                    KEYPAD: begin
                        if (take_digit) begin
                            entry.value       <= entry.value * 32'd10 + data_word_t'(digit_val);
                            entry.digit_count <= entry.digit_count + 1'b1;
                        end else if (key_valid) begin
                            case (key_coord)
                                KEY_BACKSPACE: begin
                                    if (entry.digit_count != '0) begin
                                        entry.value       <= entry.value / 32'd10;
                                        entry.digit_count <= entry.digit_count - 1'b1;
                                    end
                                end
                                KEY_SWITCH: begin
                                    state             <= SWITCH;
                                    entry.from_switch <= 1'b1;
                                end
                                KEY_ENTER: begin
                                    state             <= IDLE;
                                    entry.complete    <= 1'b1;
                                    entry.digit_count <= '0;
                                end
                                default: ;  // C, D and full-entry digits
                            endcase
                        end
                    end
                    SWITCH: begin
                        if (key_valid && key_coord == KEY_SWITCH) begin
                            state             <= KEYPAD;
                            entry.from_switch <= 1'b0;
                        end else if (key_valid && key_coord == KEY_ENTER) begin
                            state             <= IDLE;
                            entry.complete    <= 1'b1;
                            entry.digit_count <= '0;
                        end
                    end
                    PAUSE: begin
                        // a request accepted while paused opens the keypad on resume
                        if (entry.start) begin
                            resume_state <= KEYPAD;
                        end
                        if (pause_key && !ignore_pause) begin
                            state     <= entry.start ? KEYPAD : resume_state;
                            cpu_pause <= 1'b0;
                        end
                    end
                endcase
            end
        end
    end

endmodule

// ==== rtl/input_resolver.sv ====
`timescale 1ns/1ps

module input_resolver (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    output logic                    req_ready,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output input_pkg::data_word_t   rsp_data,
    output logic                    rsp_from_switch,
    input  input_pkg::switch_word_t switches,
    entry_if.resolver               entry
);
    import input_pkg::*;

    typedef enum logic [1:0] {
        PH_READY,  // free for a new request
        PH_WAIT,   // user is typing
        PH_HOLD    // response offered to the CPU
    } phase_t;

    phase_t phase;

    assign req_ready = (phase == PH_READY);
    assign rsp_valid = (phase == PH_HOLD);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase       <= PH_READY;
            entry.start <= 1'b0;
        end else begin
            entry.start <= req_valid && req_ready;
            case (phase)
                PH_READY: if (req_valid) phase <= PH_WAIT;
                PH_WAIT:  if (entry.complete) phase <= PH_HOLD;
                PH_HOLD:  if (rsp_ready) phase <= PH_READY;
                default:  phase <= PH_READY;
            endcase
        end
    end

    // response payload, held for as long as the CPU stalls
    always_ff @(posedge clk) begin
        if (phase == PH_WAIT && entry.complete) begin
            rsp_from_switch <= entry.from_switch;
            rsp_data        <= entry.from_switch ? data_word_t'(switches) : entry.value;
        end
    end

endmodule

// ==== rtl/input_subsystem.sv ====
`timescale 1ns/1ps

module input_subsystem (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic [3:0]              key_row,
    input  logic [3:0]              key_col,
    input  input_pkg::switch_word_t sw,
    input  logic                    req_valid,
    output logic                    req_ready,
    output logic                    rsp_valid,
    input  logic                    rsp_ready,
    output input_pkg::data_word_t   rsp_data,
    output logic                    rsp_from_switch,
    input  logic                    ignore_pause,
    output logic                    cpu_pause,
    output logic                    overflow_9th,
    output logic                    overflow_10th
);
    import input_pkg::*;

    logic         key_valid;
    key_coord_t   key_coord;
    switch_word_t sw_stable;  // debounced switch bank

    entry_if u_entry_if ();

    keypad_scanner u_keypad_scanner (
        .clk       (clk),
        .rst_n     (rst_n),
        .key_row   (key_row),
        .key_col   (key_col),
        .key_valid (key_valid),
        .key_coord (key_coord)
    );

    stable_filter #(
        .payload_t   (switch_word_t),
        .reset_value ('0)
    ) u_switch_filter (
        .clk    (clk),
        .rst_n  (rst_n),
        .raw    (sw),
        .stable (sw_stable)
    );

    decimal_entry u_decimal_entry (
        .clk           (clk),
        .rst_n         (rst_n),
        .key_valid     (key_valid),
        .key_coord     (key_coord),
        .ignore_pause  (ignore_pause),
        .cpu_pause     (cpu_pause),
        .overflow_9th  (overflow_9th),
        .overflow_10th (overflow_10th),
        .entry         (u_entry_if.entry)
    );

    input_resolver u_input_resolver (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_valid       (req_valid),
        .req_ready       (req_ready),
        .rsp_valid       (rsp_valid),
        .rsp_ready       (rsp_ready),
        .rsp_data        (rsp_data),
        .rsp_from_switch (rsp_from_switch),
        .switches        (sw_stable),
        .entry           (u_entry_if.resolver)
    );

endmodule

// ==== verification/keypad_model.sv ====
`timescale 1ns/1ps

module keypad_model (
    input  logic [3:0]            key_row,
    output logic [3:0]            key_col,
    input  input_pkg::key_coord_t key_code  // KEY_NONE when no key is held
);

    // a held key shorts its row line to its column line
    always_comb begin
        key_col = 4'hF;
        if ((key_row | key_code[7:4]) != 4'hF) begin  // the key's row is driven low
            key_col = key_code[3:0];
        end
    end

endmodule

// ==== verification/tb_input_subsystem.sv ====
`timescale 1ns/1ps
`include "input_defines.svh"

module tb_input_subsystem;
    import input_pkg::*;

    localparam int PRESS_CYCLES = 3 * `INPUT_SCAN_CYCLES * 4;
    localparam int WAIT_LIMIT   = 1000;
    localparam int ROWS         = 9;

    typedef struct packed {
        logic [8*14-1:0] keys;   // pad characters, right aligned, zero bytes unused
        switch_word_t    sw;
        data_word_t      data;
        logic            src;
        logic [1:0]      ovf;    // {overflow_9th, overflow_10th} before the last key
        int              stall;  // cycles rsp_ready stays low after rsp_valid
    } row_t;

    localparam key_coord_t DIGIT_KEYS [10] = '{KEY_ZERO, KEY_ONE, KEY_TWO, KEY_THREE,
        KEY_FOUR, KEY_FIVE, KEY_SIX, KEY_SEVEN, KEY_EIGHT, KEY_NINE};

    localparam row_t STIM [ROWS] = '{
        '{"0123#",        16'h0000, 32'd123,               1'b0, 2'b00, 0},
        '{"45*6#",        16'h0000, 32'd46,                1'b0, 2'b00, 0},
        '{"*#",           16'h0000, 32'd0,                 1'b0, 2'b00, 0},
        '{"123456789#",   16'h0000, 32'd123456789,         1'b0, 2'b10, 0},
        '{"99999999999#", 16'h0000, 32'(64'd9999999999),   1'b0, 2'b11, 0},
        '{"B#",           16'hA5C3, 32'h0000_A5C3,         1'b1, 2'b00, 0},
        '{"BB7#",         16'hA5C3, 32'd7,                 1'b0, 2'b00, 0},
        '{"52#",          16'h0000, 32'd52,                1'b0, 2'b00, 20},
        '{"8#",           16'h0000, 32'd8,                 1'b0, 2'b00, 0}
    };

    logic         clk;
    logic         rst_n;
    logic [3:0]   key_row;
    logic [3:0]   key_col;
    switch_word_t sw;
    logic         req_valid, req_ready;
    logic         rsp_valid, rsp_ready, rsp_from_switch;
    data_word_t   rsp_data;
    logic         ignore_pause, cpu_pause;
    logic         overflow_9th, overflow_10th;
    key_coord_t   key_code;
    int           errors;
    int           row_errors;
    int           tests;
    bit           timed_out;

    input_subsystem UUT (.*);
    keypad_model u_keypad (.*);

    always #10 clk = ~clk;

    function automatic key_coord_t key_of(input byte c);
        case (c)
            "*":     return KEY_BACKSPACE;
            "#":     return KEY_ENTER;
            "A":     return KEY_PAUSE;
            "B":     return KEY_SWITCH;
            default: return DIGIT_KEYS[c - "0"];
        endcase
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR at %0t ns: %0s is %0h, expected %0h", $time, what, got, expected);
            errors++;
            row_errors++;
        end
    endtask

    task automatic press_key(input key_coord_t code);
        key_code = code;
        repeat (PRESS_CYCLES) @(negedge clk);
        check("key_row on a held key", key_row, code[7:4]);  // scan parks on the key's row
        key_code = KEY_NONE;
        repeat (PRESS_CYCLES) @(negedge clk);
    endtask

    task automatic send_request;
        int n;
        n = 0;
        req_valid = 1'b1;
        while (!req_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!req_ready) begin
            $display("timeout: the DUT never accepted the request");
            timed_out = 1'b1;
        end
        @(negedge clk);  // handshake on the rising edge in between
        req_valid = 1'b0;
    endtask

    task automatic take_response(input data_word_t exp_data, input logic exp_src, input int stall);
        int n;
        n = 0;
        while (!rsp_valid && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!rsp_valid) begin
            $display("timeout: the DUT gave no response");
            timed_out = 1'b1;
            return;
        end
        check("rsp_data", rsp_data, exp_data);
        check("rsp_from_switch", rsp_from_switch, exp_src);
        repeat (stall) begin  // CPU stalls, response has to hold
            @(negedge clk);
            check("rsp_valid under stall", rsp_valid, 1'b1);
            check("rsp_data under stall", rsp_data, exp_data);
            check("req_ready under stall", req_ready, 1'b0);
        end
        rsp_ready = 1'b1;
        @(negedge clk);
        rsp_ready = 1'b0;
    endtask

    initial begin
        byte c;
        clk          = 1'b0;
        rst_n        = 1'b0;
        sw           = '0;
        req_valid    = 1'b0;
        rsp_ready    = 1'b0;
        ignore_pause = 1'b0;
        key_code     = KEY_NONE;
        errors       = 0;
        tests        = 0;
        timed_out    = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        for (int i = 0; i < ROWS && !timed_out; i++) begin
            row_errors = 0;
            sw = STIM[i].sw;
            send_request();
            for (int k = 13; k >= 0 && !timed_out; k--) begin
                c = STIM[i].keys[k*8 +: 8];
                if (c != 8'h00) begin
                    if (k == 0) begin  // last key, the enter
                        check("overflow_9th", overflow_9th, STIM[i].ovf[1]);
                        check("overflow_10th", overflow_10th, STIM[i].ovf[0]);
                    end
                    press_key(key_of(c));
                end
            end
            if (!timed_out) begin
                take_response(STIM[i].data, STIM[i].src, STIM[i].stall);
            end
            tests++;
            $display("row %0d %0s: %0s", i, STIM[i].keys, row_errors == 0 ? "ok" : "mismatch");
        end

        // pause, an ignored second pause, then resume and finish the entry
        if (!timed_out) begin
            row_errors = 0;
            send_request();
            press_key(KEY_PAUSE);
            check("cpu_pause after A", cpu_pause, 1'b1);
            ignore_pause = 1'b1;
            press_key(KEY_PAUSE);
            check("cpu_pause while ignored", cpu_pause, 1'b1);
            ignore_pause = 1'b0;
            press_key(KEY_PAUSE);
            check("cpu_pause after resume", cpu_pause, 1'b0);
            press_key(KEY_THREE);
            press_key(KEY_ENTER);
            take_response(32'd3, 1'b0, 0);
            tests++;
            $display("pause sequence: %0s", row_errors == 0 ? "ok" : "mismatch");
        end

        $display("%0d tests run, %0d errors%0s", tests, errors,
                 timed_out ? ", stopped by a timeout" : "");
        if (errors == 0 && !timed_out) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+rtl
rtl/input_pkg.sv
rtl/entry_if.sv
rtl/stable_filter.sv
rtl/keypad_scanner.sv
rtl/decimal_entry.sv
rtl/input_resolver.sv
rtl/input_subsystem.sv
verification/keypad_model.sv
verification/tb_input_subsystem.sv

// ==== Bender.yml ====
package:
  name: input_subsystem

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/input_pkg.sv
      - rtl/entry_if.sv
      - rtl/stable_filter.sv
      - rtl/keypad_scanner.sv
      - rtl/decimal_entry.sv
      - rtl/input_resolver.sv
      - rtl/input_subsystem.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verification/keypad_model.sv
      - verification/tb_input_subsystem.sv
